//--- Makefile
# Verilator build and run of the memory subsystem testbench
VERILATOR ?= verilator
TOP       ?= mem_system_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/mem_stim.txt
// op (0 read, 1 write, 2 read and write), byte address, write data,
// expected DataOut (reads only), expected CacheHit
0 0010 0000 0008 0
0 0016 0000 000b 1
1 0100 beef 0000 0
0 0100 0000 beef 1
1 0102 1234 0000 1
0 0102 0000 1234 1
1 0200 a5a5 0000 0
0 0a00 0000 0500 0
0 0200 0000 a5a5 0
0 0204 0000 0102 1
0 0011 0000 0000 0
2 0010 5555 0000 0
0 0010 0000 0008 1
1 0013 dead 0000 0
0 0a06 0000 0503 0
1 f808 7777 0000 0
0 0008 0000 0004 0
0 f808 0000 7777 0
0 0012 0000 0009 1

//--- bench/mem_system_asserts.sv
// ##############################
// Bound to mem_system, checks the request handshake
// Nothing is checked during reset
// ##############################
`default_nettype none

module mem_system_asserts (
   input wire clk,
   input wire reset,
   input wire Rd,
   input wire Wr,
   input wire Done,
   input wire Stall,
   input wire CacheHit,
   input wire err
);

   done_pulse: assert property (@(posedge clk) disable iff (reset) Done |=> !Done)
      else $error("Done stayed high for more than one cycle");

   // Stall may only drop together with Done
   stall_hold: assert property (@(posedge clk) disable iff (reset)
      (Stall && !Done) |=> Stall)
      else $error("Stall dropped before Done");

   no_strobe_in_stall: assert property (@(posedge clk) disable iff (reset)
      Stall |-> !(Rd || Wr))
      else $error("Rd or Wr while Stall is high");

   flags_with_done: assert property (@(posedge clk) disable iff (reset)
      (CacheHit || err) |-> Done)
      else $error("CacheHit or err without Done");

endmodule

bind mem_system mem_system_asserts u_asserts (
   .clk      (clk),
   .reset    (reset),
   .Rd       (Rd),
   .Wr       (Wr),
   .Done     (Done),
   .Stall    (Stall),
   .CacheHit (CacheHit),
   .err      (err)
);

`default_nettype wire

//--- bench/mem_system_tb.sv
// ##############################
// Run from the project root, directed requests come from bench/mem_stim.txt
// Random tail uses seed 95 on a few lines that collide on index
// ##############################
`default_nettype none
`include "mem_sys_consts.svh"

module mem_system_tb;

   localparam int STIM_MAX    = 64;
   localparam int STIM_COLS   = 5;
   localparam int N_RANDOM    = 200;
   localparam int RST_CYC     = 16;
   localparam int PERIOD      = 40;
   localparam int CYC_PER_REQ = 20;
   localparam int LINES       = 1 << `MS_INDEX_W;

   logic               clk;
   logic               reset;
   mem_sys_pkg::word_t Addr;
   mem_sys_pkg::word_t DataIn;
   logic               Rd;
   logic               Wr;
   mem_sys_pkg::word_t DataOut;
   logic               Done;
   logic               Stall;
   logic               CacheHit;
   logic               err;

   mem_sys_pkg::word_t stim [STIM_MAX*STIM_COLS];
   // Architectural memory plus the direct-mapped tag state
   mem_sys_pkg::word_t ref_mem [`MS_MEM_WORDS];
   mem_sys_pkg::tag_t  ref_tag [LINES];
   logic [LINES-1:0]   ref_valid;

   int     n_dir;
   int     n_req;
   int     n_tests;
   int     n_bad_tests;
   int     errors;
   integer seed;

   mem_system i_dut (
      .clk      (clk),
      .reset    (reset),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .Rd       (Rd),
      .Wr       (Wr),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   task automatic check_word(input string name, input mem_sys_pkg::word_t got,
                             input mem_sys_pkg::word_t exp);
      if (got !== exp) begin
         $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error at time %0t: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   // Direct-mapped rule on the model's tag state
   function automatic logic predict_hit(input mem_sys_pkg::word_t addr);
      mem_sys_pkg::index_t idx;
      idx = addr[`MS_OFFSET_W +: `MS_INDEX_W];
      return ref_valid[idx] && ref_tag[idx] == addr[`MS_WORD_W-1 -: `MS_TAG_W];
   endfunction

   // op 0 read, 1 write, 2 read and write together
   task automatic run_request(input logic [1:0] op, input mem_sys_pkg::word_t addr,
                              input mem_sys_pkg::word_t data,
                              input mem_sys_pkg::word_t exp_data, input logic exp_hit);
      int                  errors_before;
      logic                bad;
      mem_sys_pkg::index_t idx;
      errors_before = errors;
      bad = addr[0] || op == 2'd2;
      idx = addr[`MS_OFFSET_W +: `MS_INDEX_W];
      @(posedge clk);
      Addr   <= addr;
      DataIn <= data;
      Rd     <= op != 2'd1;
      Wr     <= op != 2'd0;
      @(posedge clk);
      Rd <= 1'b0;
      Wr <= 1'b0;
      @(negedge clk);
      // Stall covers every cycle between the strobe and Done
      while (!Done) begin
         check_bit("Stall", Stall, 1'b1);
         @(negedge clk);
      end
      check_bit("err", err, bad);
      check_bit("CacheHit", CacheHit, exp_hit && !bad);
      if (op == 2'd0 && !bad) begin
         check_word("DataOut", DataOut, exp_data);
      end
      // Errors leave the model alone
      if (!bad) begin
         if (op == 2'd1) begin
            ref_mem[addr[`MS_WORD_W-1:1]] = data;
         end
         ref_valid[idx] = 1'b1;
         ref_tag[idx]   = addr[`MS_WORD_W-1 -: `MS_TAG_W];
      end
      n_tests++;
      if (errors != errors_before) begin
         n_bad_tests++;
      end
      $display("test %0d op %0d addr %h: %s", n_tests, op, addr,
               errors == errors_before ? "ok" : "mismatch");
   endtask

   initial begin
      logic [31:0]        r;
      logic [1:0]         op;
      mem_sys_pkg::word_t addr;
      mem_sys_pkg::word_t data;
      reset  = 1'b1;
      Addr   = '0;
      DataIn = '0;
      Rd     = 1'b0;
      Wr     = 1'b0;
      seed   = 95;
      n_dir  = 0;
      n_req  = 0;
      foreach (stim[i]) stim[i] = 16'hffff;
      $readmemh("bench/mem_stim.txt", stim);
      while (n_dir < STIM_MAX && stim[n_dir*STIM_COLS] != 16'hffff) n_dir++;
      if (n_dir == 0) begin
         $display("No directed requests could be read from bench/mem_stim.txt");
         errors++;
      end
      n_req = n_dir + N_RANDOM;
      for (int i = 0; i < `MS_MEM_WORDS; i++) begin
         ref_mem[i] = mem_sys_pkg::word_t'(i);
      end
      ref_valid = '0;
      repeat (RST_CYC) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < n_dir; i++) begin
         run_request(stim[i*STIM_COLS][1:0], stim[i*STIM_COLS+1], stim[i*STIM_COLS+2],
                     stim[i*STIM_COLS+3], stim[i*STIM_COLS+4][0]);
      end

      // Tags 0 to 3 on indexes 0x30 and 0x31, an odd address now and then
      for (int i = 0; i < N_RANDOM; i++) begin
         r    = $random(seed);
         data = mem_sys_pkg::word_t'($random(seed));
         op   = (r[4:0] == 5'd0) ? 2'd2 : {1'b0, r[0]};
         addr = {3'b000, r[9:8], 7'b0011000, r[10], r[12:11], r[17:13] == 5'd0};
         run_request(op, addr, data, ref_mem[addr[`MS_WORD_W-1:1]], predict_hit(addr));
      end

      @(posedge clk);
      $display("%0d tests run, %0d with mismatches, %0d errors", n_tests, n_bad_tests, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Budget of 20 cycles per request after reset
   initial begin
      wait (n_req > 0);
      #((RST_CYC + n_req * CYC_PER_REQ) * PERIOD);
      $display("Timeout: the requests did not all finish in time");
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/bank_mem_if.sv
// ############################
// Master holds addr, rd and wr while stall is high
// ############################
`default_nettype none
`include "mem_sys_consts.svh"

interface bank_mem_if;

   mem_sys_pkg::word_t      addr;
   mem_sys_pkg::word_t      data_in;
   logic                    rd;
   logic                    wr;
   mem_sys_pkg::word_t      data_out;
   logic                    stall;
   // One bit per bank
   logic [`MS_BANKS-1:0]    busy;

   modport master (output addr, data_in, rd, wr, input data_out, stall, busy);
   modport slave  (input addr, data_in, rd, wr, output data_out, stall, busy);

endinterface

`default_nettype wire

//--- rtl/cache_ctrl.sv
// ############################
// One request in flight, strobes only accepted in IDLE
// Line transfers start one word past the requested word,
// so a read miss ends with the requested word on memory data
// ############################
`default_nettype none
`include "mem_sys_consts.svh"

module cache_ctrl (
   input wire                 clk,
   input wire                 reset,
   input wire mem_sys_pkg::word_t addr,
   input wire mem_sys_pkg::word_t data_req,
   input wire                 rd,
   input wire                 wr,
   cache_port_if.master       cache,
   bank_mem_if.master         mem,
   output logic               write_sel,
   output logic               sel,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err
);

   localparam int CNT_W = $clog2(`MS_LINE_WORDS);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`MS_LINE_WORDS - 1);

   mem_sys_pkg::ctrl_state_t state;
   mem_sys_pkg::ctrl_state_t state_nxt;

   // Latched request
   mem_sys_pkg::tag_t     tag_q;
   mem_sys_pkg::index_t   index_q;
   mem_sys_pkg::offset_t  offset_q;
   mem_sys_pkg::word_t    data_q;
   logic                  is_wr_q;
   logic                  err_q;
   logic                  missed_q;

   logic [CNT_W-1:0]      issue_cnt;
   logic [CNT_W-1:0]      ret_cnt;
   logic [CNT_W-1:0]      start_word;
   logic [CNT_W-1:0]      issue_word;
   logic [CNT_W-1:0]      ret_word;
   // Accepted reads moving toward their return cycle
   logic [`MS_RD_LAT-1:0] inflight;
   logic                  rd_accept;
   logic                  rd_return;
   logic                  strobe;
   logic                  bad_req;

   assign strobe     = rd || wr;
   assign bad_req    = addr[0] || (rd && wr);
   assign start_word = offset_q[CNT_W:1] + 1'b1;
   assign issue_word = start_word + issue_cnt;
   assign ret_word   = start_word + ret_cnt;
   assign rd_accept  = mem.rd && !mem.stall;
   assign rd_return  = inflight[`MS_RD_LAT-1];

   always_ff @(posedge clk) begin
      if (state == mem_sys_pkg::IDLE && strobe) begin
         tag_q    <= addr[`MS_WORD_W-1 -: `MS_TAG_W];
         index_q  <= addr[`MS_OFFSET_W +: `MS_INDEX_W];
         offset_q <= addr[`MS_OFFSET_W-1:0];
         data_q   <= data_req;
         is_wr_q  <= wr;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= mem_sys_pkg::IDLE;
         issue_cnt <= '0;
         ret_cnt   <= '0;
         inflight  <= '0;
         err_q     <= 1'b0;
         missed_q  <= 1'b0;
      end else begin
         state    <= state_nxt;
         inflight <= {inflight[`MS_RD_LAT-2:0], rd_accept};
         if (state == mem_sys_pkg::IDLE && strobe) begin
            err_q    <= bad_req;
            missed_q <= 1'b0;
         end
         if (state == mem_sys_pkg::COMPARE && !cache.hit) begin
            missed_q <= 1'b1;
         end
         // Issue count wraps to zero after the writeback
         if (state == mem_sys_pkg::COMPARE) begin
            issue_cnt <= '0;
         end else if ((state == mem_sys_pkg::WB_ISSUE && !mem.stall) || rd_accept) begin
            issue_cnt <= issue_cnt + 1'b1;
         end
         if (state == mem_sys_pkg::COMPARE) begin
            ret_cnt <= '0;
         end else if (rd_return) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         mem_sys_pkg::IDLE: begin
            if (strobe) begin
               state_nxt = bad_req ? mem_sys_pkg::FINISH : mem_sys_pkg::COMPARE;
            end
         end
         mem_sys_pkg::COMPARE: begin
            if (cache.hit) begin
               state_nxt = mem_sys_pkg::FINISH;
            end else if (cache.valid && cache.dirty) begin
               state_nxt = mem_sys_pkg::WB_ISSUE;
            end else begin
               state_nxt = mem_sys_pkg::ALLOC_ISSUE;
            end
         end
         mem_sys_pkg::WB_ISSUE: begin
            if (!mem.stall && issue_cnt == LAST) begin
               state_nxt = mem_sys_pkg::WB_WAIT;
            end
         end
         // Hold off reads until the first bank is free again
         mem_sys_pkg::WB_WAIT: begin
            if (!mem.busy[start_word]) begin
               state_nxt = mem_sys_pkg::ALLOC_ISSUE;
            end
         end
         mem_sys_pkg::ALLOC_ISSUE: begin
            if (rd_accept && issue_cnt == LAST) begin
               state_nxt = mem_sys_pkg::ALLOC_FILL;
            end
         end
         mem_sys_pkg::ALLOC_FILL: begin
            if (rd_return && ret_cnt == LAST) begin
               state_nxt = mem_sys_pkg::COMPARE;
            end
         end
         default: begin
            state_nxt = mem_sys_pkg::IDLE;
         end
      endcase
   end

   always_comb begin
      cache.enable   = state != mem_sys_pkg::IDLE;
      cache.tag_in   = tag_q;
      cache.index    = index_q;
      cache.offset   = offset_q;
      cache.data_in  = data_q;
      cache.comp     = 1'b1;
      cache.write    = 1'b0;
      cache.valid_in = 1'b1;
      // Victim address comes from the stored tag
      mem.addr       = {cache.tag_out, index_q, issue_word, 1'b0};
      mem.data_in    = cache.data_out;
      mem.rd         = 1'b0;
      mem.wr         = 1'b0;
      write_sel      = 1'b0;
      case (state)
         mem_sys_pkg::COMPARE: begin
            cache.write = is_wr_q;
            write_sel   = 1'b1;
         end
         mem_sys_pkg::WB_ISSUE: begin
            cache.offset = {issue_word, 1'b0};
            mem.wr       = 1'b1;
         end
         mem_sys_pkg::ALLOC_ISSUE, mem_sys_pkg::ALLOC_FILL: begin
            mem.addr     = {tag_q, index_q, issue_word, 1'b0};
            mem.rd       = state == mem_sys_pkg::ALLOC_ISSUE;
            cache.offset = {ret_word, 1'b0};
            cache.comp   = 1'b0;
            cache.write  = rd_return;
         end
         default: begin
         end
      endcase
   end

   assign done      = state == mem_sys_pkg::FINISH;
   assign stall     = state != mem_sys_pkg::IDLE;
   assign cache_hit = done && !missed_q && !err_q;
   assign err       = done && err_q;
   assign sel       = done && missed_q && !is_wr_q;

endmodule

`default_nettype wire

//--- rtl/cache_port_if.sv
// ############################
// Lookup outputs are combinational on index and offset
// Writes land at the rising edge
// ############################
`default_nettype none

interface cache_port_if;

   logic                  enable;
   mem_sys_pkg::tag_t     tag_in;
   mem_sys_pkg::index_t   index;
   mem_sys_pkg::offset_t  offset;
   mem_sys_pkg::word_t    data_in;
   // Write data after the fill multiplexer at the top level
   mem_sys_pkg::word_t    fill_data;
   logic                  comp;
   logic                  write;
   logic                  valid_in;

   mem_sys_pkg::tag_t     tag_out;
   mem_sys_pkg::word_t    data_out;
   logic                  hit;
   logic                  dirty;
   logic                  valid;

   modport master (
      output enable, tag_in, index, offset, data_in, comp, write, valid_in,
      input  tag_out, data_out, hit, dirty, valid
   );

   modport slave (
      input  enable, tag_in, index, offset, fill_data, comp, write, valid_in,
      output tag_out, data_out, hit, dirty, valid
   );

endinterface

`default_nettype wire

//--- rtl/dm_cache.sv
// ############################
// Direct mapped, one word per access
// Offset bit 0 is ignored since accesses are word aligned
// ############################
`default_nettype none
`include "mem_sys_consts.svh"

module dm_cache (
   input wire          clk,
   input wire          reset,
   cache_port_if.slave port
);

   localparam int LINES  = 1 << `MS_INDEX_W;
   localparam int WSEL_W = $clog2(`MS_LINE_WORDS);

   mem_sys_pkg::tag_t  tag_q  [LINES];
   mem_sys_pkg::word_t data_q [LINES][`MS_LINE_WORDS];
   logic [LINES-1:0]   valid_q;
   logic [LINES-1:0]   dirty_q;

   logic [WSEL_W-1:0]  wsel;
   logic               tag_match;
   logic               fill_wr;
   logic               line_wr;

   assign wsel      = port.offset[WSEL_W:1];
   assign tag_match = tag_q[port.index] == port.tag_in;

   assign port.tag_out  = tag_q[port.index];
   assign port.valid    = valid_q[port.index];
   assign port.dirty    = dirty_q[port.index];
   assign port.hit      = port.enable && valid_q[port.index] && tag_match;
   assign port.data_out = data_q[port.index][wsel];

   // Fill writes always land, compare writes only on a hit
   assign fill_wr = port.enable && port.write && !port.comp;
   assign line_wr = fill_wr || (port.enable && port.write && port.hit);

   always_ff @(posedge clk) begin
      if (line_wr) begin
         data_q[port.index][wsel] <= port.fill_data;
      end
      if (fill_wr) begin
         tag_q[port.index] <= port.tag_in;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (fill_wr) begin
         valid_q[port.index] <= port.valid_in;
         dirty_q[port.index] <= 1'b0;
      end else if (line_wr) begin
         // Compare mode write hit
         dirty_q[port.index] <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/four_bank_mem.sv
// ############################
// Banks interleave on address bits 2 to 1
// Each word starts out holding its own word address
// Read data holds until the next read returns
// ############################
`default_nettype none
`include "mem_sys_consts.svh"

module four_bank_mem (
   input wire         clk,
   input wire         reset,
   bank_mem_if.slave  port
);

   localparam int ROWS   = `MS_MEM_WORDS / `MS_BANKS;
   localparam int ROW_W  = $clog2(ROWS);
   localparam int BANK_W = $clog2(`MS_BANKS);
   localparam int CNT_W  = $clog2(`MS_BANK_BUSY + 1);
   // Stages before the output register
   localparam int PIPE   = `MS_RD_LAT - 1;

   mem_sys_pkg::word_t bank_q [`MS_BANKS][ROWS];
   logic [CNT_W-1:0]   busy_cnt [`MS_BANKS];
   mem_sys_pkg::word_t rd_pipe [PIPE];
   logic [PIPE-1:0]    rd_valid;
   mem_sys_pkg::word_t out_q;

   logic [BANK_W-1:0]  bank;
   logic [ROW_W-1:0]   row;
   logic               accept;

   assign bank = port.addr[BANK_W:1];
   assign row  = port.addr[`MS_WORD_W-1 -: ROW_W];

   always_comb begin
      for (int b = 0; b < `MS_BANKS; b++) begin
         port.busy[b] = busy_cnt[b] != '0;
      end
   end

   assign port.stall    = (port.rd || port.wr) && port.busy[bank];
   assign accept        = (port.rd || port.wr) && !port.busy[bank];
   assign port.data_out = out_q;

   initial begin
      for (int b = 0; b < `MS_BANKS; b++) begin
         for (int r = 0; r < ROWS; r++) begin
            bank_q[b][r] = mem_sys_pkg::word_t'(r * `MS_BANKS + b);
         end
      end
   end

   always @(posedge clk) begin
      if (accept && port.wr) begin
         bank_q[bank][row] <= port.data_in;
      end
   end

   // Busy countdown per bank
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < `MS_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `MS_BANKS; b++) begin
            if (accept && bank == BANK_W'(b)) begin
               busy_cnt[b] <= CNT_W'(`MS_BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= '0;
      end else begin
         rd_valid <= (rd_valid << 1) | PIPE'(accept && port.rd && !port.wr);
      end
   end

   always_ff @(posedge clk) begin
      rd_pipe[0] <= bank_q[bank][row];
      for (int s = 1; s < PIPE; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
      if (rd_valid[PIPE-1]) begin
         out_q <= rd_pipe[PIPE-1];
      end
   end

endmodule

`default_nettype wire

//--- rtl/mem_sys_consts.svh
// ############################
// Widths assume a 16-bit word and byte addresses
// Timing values count clock cycles
// ############################
`ifndef MEM_SYS_CONSTS_SVH
`define MEM_SYS_CONSTS_SVH

`define MS_WORD_W      16
`define MS_TAG_W       5
`define MS_INDEX_W     8
`define MS_OFFSET_W    3
`define MS_LINE_WORDS  4
`define MS_BANKS       4
// Bank busy time after one access, and read latency
`define MS_BANK_BUSY   4
`define MS_RD_LAT      2
`define MS_MEM_WORDS   32768

`endif

//--- rtl/mem_sys_pkg.sv
// ############################
// Address split is tag, index, byte offset from MSB down
// ############################
`default_nettype none
`include "mem_sys_consts.svh"

package mem_sys_pkg;

   typedef logic [`MS_WORD_W-1:0]   word_t;
   typedef logic [`MS_TAG_W-1:0]    tag_t;
   typedef logic [`MS_INDEX_W-1:0]  index_t;
   typedef logic [`MS_OFFSET_W-1:0] offset_t;

   // Cache controller request FSM
   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      WB_ISSUE,
      WB_WAIT,
      ALLOC_ISSUE,
      ALLOC_FILL,
      FINISH
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/mem_system.sv
// ############################
// Rd or Wr is a one-cycle strobe, only while Stall is low
// CacheHit and err mean something only with Done
// ############################
`default_nettype none

module mem_system (
   input wire                      clk,
   input wire                      reset,
   input wire mem_sys_pkg::word_t  Addr,
   input wire mem_sys_pkg::word_t  DataIn,
   input wire                      Rd,
   input wire                      Wr,
   output mem_sys_pkg::word_t      DataOut,
   output logic                    Done,
   output logic                    Stall,
   output logic                    CacheHit,
   output logic                    err
);

   logic write_sel;
   logic sel;

   cache_port_if cache_bus ();
   bank_mem_if   mem_bus ();

   cache_ctrl u_ctrl (
      .clk       (clk),
      .reset     (reset),
      .addr      (Addr),
      .data_req  (DataIn),
      .rd        (Rd),
      .wr        (Wr),
      .cache     (cache_bus),
      .mem       (mem_bus),
      .write_sel (write_sel),
      .sel       (sel),
      .done      (Done),
      .stall     (Stall),
      .cache_hit (CacheHit),
      .err       (err)
   );

   dm_cache u_cache (
      .clk   (clk),
      .reset (reset),
      .port  (cache_bus)
   );

   four_bank_mem u_mem (
      .clk   (clk),
      .reset (reset),
      .port  (mem_bus)
   );

   // Request data on a write hit, memory data during allocate
   assign cache_bus.fill_data = write_sel ? cache_bus.data_in : mem_bus.data_out;

   // Read misses finish with the requested word still on memory data
   assign DataOut = sel ? mem_bus.data_out : cache_bus.data_out;

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/mem_sys_pkg.sv
rtl/cache_port_if.sv
rtl/bank_mem_if.sv
rtl/dm_cache.sv
rtl/four_bank_mem.sv
rtl/cache_ctrl.sv
rtl/mem_system.sv
bench/mem_system_asserts.sv
bench/mem_system_tb.sv
